/* ecc_pkg.sv */
package ecc_pkg;

    // ********************************************************************
    // Code geometry
    // ********************************************************************

    // Fixed by the parity equations of the 40/7 SECDED code.
    localparam int ECC_DATA_WIDTH  = 40;
    localparam int ECC_CHECK_WIDTH = 7;

    // Stored word with check bits in the upper field.
    typedef struct packed {
        logic [ECC_CHECK_WIDTH-1:0] check;
        logic [ECC_DATA_WIDTH-1:0]  data;
    } ecc_codeword_t;

    // ********************************************************************
    // Port types
    // ********************************************************************

    typedef enum logic [1:0] {
        MEM_READ      = 2'd0,
        MEM_WRITE     = 2'd1,
        MEM_WRITE_RAW = 2'd2,
        MEM_READ_RAW  = 2'd3
    } mem_op_e;

    // The check field of wword matters for raw writes only.
    typedef struct packed {
        mem_op_e       op;
        ecc_codeword_t wword;
    } mem_req_t;

    typedef enum logic [1:0] {
        ECC_OK            = 2'd0,
        ECC_CORRECTED     = 2'd1,
        ECC_UNCORRECTABLE = 2'd2
    } ecc_status_e;

    typedef struct packed {
        ecc_codeword_t rword;
        ecc_status_e   status;
    } mem_rsp_t;

    // Single-cycle pulses towards the error log.
    typedef struct packed {
        logic corrected;
        logic uncorrectable;
    } ecc_event_t;

endpackage

/* ecc_secded_40.sv */
`timescale 1ns/1ps

module ecc_secded_40 import ecc_pkg::*; (
    input  logic [ECC_DATA_WIDTH-1:0]  data_in,
    input  logic [ECC_CHECK_WIDTH-1:0] parity_in,
    input  logic                       bypass,
    output logic [ECC_DATA_WIDTH-1:0]  data_out,
    output logic [ECC_CHECK_WIDTH-1:0] parity_out,
    output ecc_status_e                status
);

    // ********************************************************************
    // Parity equations
    // ********************************************************************

    // One row per check bit. Bit j of a row set means data bit j feeds it.
    localparam logic [ECC_CHECK_WIDTH-1:0][ECC_DATA_WIDTH-1:0] PARITY_MASK = {
        40'hD32DA65CB7,
        40'hFFFC000000,
        40'h0003FFF800,
        40'hFE03FC07F0,
        40'hE1E3C3C78E,
        40'h999B33366D,
        40'h5556AAAD5B
    };

    logic [ECC_CHECK_WIDTH-1:0] syndrome;
    logic [ECC_DATA_WIDTH-1:0]  flip;
    logic                       check_hit;

    function automatic logic [ECC_CHECK_WIDTH-1:0] ecc_encode(
        input logic [ECC_DATA_WIDTH-1:0] d
    );
        logic [ECC_CHECK_WIDTH-1:0] p;
        for (int i = 0; i < ECC_CHECK_WIDTH; i++) begin
            p[i] = ^(d & PARITY_MASK[i]);
        end
        return p;
    endfunction

    assign parity_out = ecc_encode(data_in);
    assign syndrome   = parity_in ^ parity_out;

    // ********************************************************************
    // Syndrome decode
    // ********************************************************************

    // Each data bit owns the syndrome equal to its column of the mask table.
    always_comb begin : decode_columns
        logic [ECC_CHECK_WIDTH-1:0] column;
        flip = '0;
        for (int j = 0; j < ECC_DATA_WIDTH; j++) begin
            for (int i = 0; i < ECC_CHECK_WIDTH; i++) begin
                column[i] = PARITY_MASK[i][j];
            end
            flip[j] = (syndrome == column);
        end
    end

    // A lone syndrome bit points at a flipped check bit.
    assign check_hit = (syndrome != '0) &&
                       ((syndrome & (syndrome - 7'd1)) == '0);

    assign data_out = bypass ? data_in : (data_in ^ flip);

    always_comb begin
        if (bypass) begin
            status = ECC_OK;
        end else if (syndrome == '0) begin
            status = ECC_OK;
        end else if ((|flip) || check_hit) begin
            status = ECC_CORRECTED;
        end else begin
            status = ECC_UNCORRECTABLE;
        end
    end

endmodule

/* ecc_mem_array.sv */
`timescale 1ns/1ps

module ecc_mem_array import ecc_pkg::*; #(
    parameter int ADDR_WIDTH = 4
) (
    input  logic                  clk,
    input  logic [ADDR_WIDTH-1:0] addr,
    input  logic                  we,
    input  ecc_codeword_t         wword,
    output ecc_codeword_t         rword
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    ecc_codeword_t mem [DEPTH];

    // Read data is registered. A write returns the old word.
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wword;
        end
        rword <= mem[addr];
    end

    // An unknown write enable would corrupt the stored codewords.
    a_we_known: assert property (@(posedge clk) !$isunknown(we))
        else $error("array write enable is unknown");

endmodule

/* ecc_mem_ctrl.sv */
`timescale 1ns/1ps

module ecc_mem_ctrl import ecc_pkg::*; #(
    parameter int ADDR_WIDTH = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        req,
    input  logic [ADDR_WIDTH-1:0]       addr,
    input  mem_req_t                    mreq,
    input  logic [ECC_DATA_WIDTH-1:0]   cdata,
    input  logic [ECC_CHECK_WIDTH-1:0]  ccheck,
    input  ecc_status_e                 cstatus,
    input  ecc_codeword_t               arr_rword,
    output logic                        ack,
    output mem_rsp_t                    rsp,
    output logic [ADDR_WIDTH-1:0]       arr_addr,
    output logic                        arr_we,
    output ecc_codeword_t               arr_wword,
    output logic [ECC_DATA_WIDTH-1:0]   cdata_in,
    output logic [ECC_CHECK_WIDTH-1:0]  ccheck_in,
    output logic                        cbypass,
    output ecc_event_t                  err_event,
    output logic [ADDR_WIDTH-1:0]       event_addr
);

    typedef enum logic [1:0] {
        IDLE,
        READ_WAIT,
        WRITE_BACK,
        ACK_HOLD
    } state_e;

    state_e        state_q;
    mem_op_e       op_q;
    logic          is_write;
    ecc_codeword_t enc_word;

    assign is_write = (mreq.op == MEM_WRITE) || (mreq.op == MEM_WRITE_RAW);

    // ********************************************************************
    // Array and codec steering
    // ********************************************************************

    // The master holds addr until ack, so it addresses the array directly.
    assign arr_addr = addr;

    always_comb begin
        cdata_in  = mreq.wword.data;
        ccheck_in = mreq.wword.check;
        cbypass   = 1'b0;
        case (state_q)
            READ_WAIT: begin
                cdata_in  = arr_rword.data;
                ccheck_in = arr_rword.check;
                cbypass   = (op_q == MEM_READ_RAW);
            end
            // Re-encode the corrected data held in the response register.
            WRITE_BACK: begin
                cdata_in  = rsp.rword.data;
                ccheck_in = rsp.rword.check;
            end
            default: begin
            end
        endcase
    end

    assign enc_word = '{check: ccheck, data: cdata_in};

    assign arr_wword = ((state_q == IDLE) && (mreq.op == MEM_WRITE_RAW)) ? mreq.wword
                                                                          : enc_word;

    assign arr_we = req && (((state_q == IDLE) && is_write) || (state_q == WRITE_BACK));

    // ********************************************************************
    // Handshake FSM
    // ********************************************************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= IDLE;
            ack       <= 1'b0;
            err_event <= '0;
        end else begin
            err_event <= '0;
            case (state_q)
                IDLE: begin
                    if (req && is_write) begin
                        ack     <= 1'b1;
                        state_q <= ACK_HOLD;
                    end else if (req) begin
                        state_q <= READ_WAIT;
                    end
                end
                READ_WAIT: begin
                    err_event.corrected     <= (cstatus == ECC_CORRECTED);
                    err_event.uncorrectable <= (cstatus == ECC_UNCORRECTABLE);
                    if (cstatus == ECC_CORRECTED) begin
                        state_q <= WRITE_BACK;
                    end else begin
                        ack     <= 1'b1;
                        state_q <= ACK_HOLD;
                    end
                end
                WRITE_BACK: begin
                    ack     <= 1'b1;
                    state_q <= ACK_HOLD;
                end
                ACK_HOLD: begin
                    if (!req) begin
                        ack     <= 1'b0;
                        state_q <= IDLE;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // Response payload.
    always_ff @(posedge clk) begin
        if ((state_q == IDLE) && req) begin
            op_q <= mreq.op;
            if (is_write) begin
                rsp.rword  <= arr_wword;
                rsp.status <= ECC_OK;
            end
        end
        // Corrected data goes out with the check bits as stored.
        if (state_q == READ_WAIT) begin
            rsp.rword  <= '{check: arr_rword.check, data: cdata};
            rsp.status <= cstatus;
            event_addr <= addr;
        end
    end

    a_ack_after_req: assert property (
        @(posedge clk) disable iff (!rst_n) $fell(ack) |-> !$past(req)
    ) else $error("ack dropped while req was still high");

endmodule

/* ecc_err_log.sv */
`timescale 1ns/1ps

module ecc_err_log import ecc_pkg::*; #(
    parameter int ADDR_WIDTH = 4,
    parameter int CNT_WIDTH  = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  ecc_event_t            err_event,
    input  logic [ADDR_WIDTH-1:0] event_addr,
    output logic [CNT_WIDTH-1:0]  corr_count,
    output logic [CNT_WIDTH-1:0]  uncorr_count,
    output logic [ADDR_WIDTH-1:0] last_err_addr
);

    logic corr_full;
    logic uncorr_full;

    // Counters stick at all ones.
    assign corr_full   = &corr_count;
    assign uncorr_full = &uncorr_count;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            corr_count    <= '0;
            uncorr_count  <= '0;
            last_err_addr <= '0;
        end else begin
            if (err_event.corrected && !corr_full) begin
                corr_count <= corr_count + 1'b1;
            end
            if (err_event.uncorrectable && !uncorr_full) begin
                uncorr_count <= uncorr_count + 1'b1;
            end
            if (err_event.corrected || err_event.uncorrectable) begin
                last_err_addr <= event_addr;
            end
        end
    end

endmodule

/* ecc_mem_top.sv */
`timescale 1ns/1ps

module ecc_mem_top import ecc_pkg::*; #(
    parameter int ADDR_WIDTH = 4,
    parameter int CNT_WIDTH  = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req,
    input  logic [ADDR_WIDTH-1:0] addr,
    input  mem_req_t              mreq,
    output logic                  ack,
    output mem_rsp_t              rsp,
    output logic [CNT_WIDTH-1:0]  corr_count,
    output logic [CNT_WIDTH-1:0]  uncorr_count,
    output logic [ADDR_WIDTH-1:0] last_err_addr
);

    logic [ADDR_WIDTH-1:0]      arr_addr;
    logic                       arr_we;
    ecc_codeword_t              arr_wword;
    ecc_codeword_t              arr_rword;
    logic [ECC_DATA_WIDTH-1:0]  cdata_in;
    logic [ECC_CHECK_WIDTH-1:0] ccheck_in;
    logic                       cbypass;
    logic [ECC_DATA_WIDTH-1:0]  cdata;
    logic [ECC_CHECK_WIDTH-1:0] ccheck;
    ecc_status_e                cstatus;
    ecc_event_t                 err_event;
    logic [ADDR_WIDTH-1:0]      event_addr;

    ecc_mem_ctrl #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) i_ecc_mem_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .addr       (addr),
        .mreq       (mreq),
        .cdata      (cdata),
        .ccheck     (ccheck),
        .cstatus    (cstatus),
        .arr_rword  (arr_rword),
        .ack        (ack),
        .rsp        (rsp),
        .arr_addr   (arr_addr),
        .arr_we     (arr_we),
        .arr_wword  (arr_wword),
        .cdata_in   (cdata_in),
        .ccheck_in  (ccheck_in),
        .cbypass    (cbypass),
        .err_event  (err_event),
        .event_addr (event_addr)
    );

    ecc_secded_40 i_ecc_secded_40 (
        .data_in    (cdata_in),
        .parity_in  (ccheck_in),
        .bypass     (cbypass),
        .data_out   (cdata),
        .parity_out (ccheck),
        .status     (cstatus)
    );

    ecc_mem_array #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) i_ecc_mem_array (
        .clk   (clk),
        .addr  (arr_addr),
        .we    (arr_we),
        .wword (arr_wword),
        .rword (arr_rword)
    );

    ecc_err_log #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .CNT_WIDTH  (CNT_WIDTH)
    ) i_ecc_err_log (
        .clk           (clk),
        .rst_n         (rst_n),
        .err_event     (err_event),
        .event_addr    (event_addr),
        .corr_count    (corr_count),
        .uncorr_count  (uncorr_count),
        .last_err_addr (last_err_addr)
    );

endmodule

/* tb_ecc_mem_top.sv */
`timescale 1ns/1ps

module tb_ecc_mem_top import ecc_pkg::*; ();

    localparam int ADDR_WIDTH   = 4;
    localparam int CNT_WIDTH    = 8;
    localparam int GOLDEN_WORDS = 256;
    localparam int WAIT_LIMIT   = 50;
    localparam logic [ECC_DATA_WIDTH-1:0] END_MARK = 40'hE;

    logic                        clk;
    logic                        rst_n;
    logic                        req;
    logic [ADDR_WIDTH-1:0]       addr;
    mem_req_t                    mreq;
    logic                        ack;
    mem_rsp_t                    rsp;
    logic [CNT_WIDTH-1:0]        corr_count;
    logic [CNT_WIDTH-1:0]        uncorr_count;
    logic [ADDR_WIDTH-1:0]       last_err_addr;
    logic [ECC_DATA_WIDTH-1:0]   golden [GOLDEN_WORDS];

    ecc_mem_top #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .CNT_WIDTH  (CNT_WIDTH)
    ) i_ecc_mem_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .req           (req),
        .addr          (addr),
        .mreq          (mreq),
        .ack           (ack),
        .rsp           (rsp),
        .corr_count    (corr_count),
        .uncorr_count  (uncorr_count),
        .last_err_addr (last_err_addr)
    );

    always #10 clk = ~clk;

    // ********************************************************************
    // Helpers
    // ********************************************************************

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input logic [39:0] got,
                               input logic [39:0] expected);
        assert (got === expected)
            else abort_run($sformatf("CHECK FAILED at time %0t: %s is %h, expected %h",
                                     $time, name, got, expected));
    endtask

    // Counts falling edges until ack reaches the wanted level.
    task automatic wait_for_ack(input logic level, output int cycles);
        cycles = 0;
        while (ack !== level) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                abort_run($sformatf("ack did not go to %0b within %0d cycles.",
                                    level, WAIT_LIMIT));
            end
        end
    endtask

    // Called on a falling edge. One full four-phase handshake.
    task automatic run_operation(input mem_op_e op, input logic [ADDR_WIDTH-1:0] a,
                                 input ecc_codeword_t wword, input ecc_codeword_t exp_word,
                                 input ecc_status_e exp_status);
        int latency;
        int exp_latency;
        int hold;
        addr       = a;
        mreq.op    = op;
        mreq.wword = wword;
        req        = 1'b1;
        wait_for_ack(1'b1, latency);
        // Writes 1 cycle, reads 2, corrected reads add the write-back cycle.
        if ((op == MEM_WRITE) || (op == MEM_WRITE_RAW)) begin
            exp_latency = 1;
        end else if (exp_status == ECC_CORRECTED) begin
            exp_latency = 3;
        end else begin
            exp_latency = 2;
        end
        check_value("ack latency", latency, exp_latency);
        check_value("rsp.rword.data", rsp.rword.data, exp_word.data);
        check_value("rsp.rword.check", rsp.rword.check, exp_word.check);
        check_value("rsp.status", rsp.status, exp_status);
        // A slow master keeps req up, ack has to stay with it.
        hold = $urandom % 3;
        repeat (hold) begin
            @(negedge clk);
            assert (ack === 1'b1)
                else abort_run("ack fell while req was still high.");
        end
        req = 1'b0;
        wait_for_ack(1'b0, latency);
        repeat ($urandom % 4) @(negedge clk);
    endtask

    // ********************************************************************
    // Golden replay
    // ********************************************************************

    initial begin : replay
        int            pos;
        mem_op_e       op;
        ecc_codeword_t wword;
        ecc_codeword_t exp_word;
        ecc_status_e   exp_status;
        clk   = 1'b0;
        rst_n = 1'b0;
        req   = 1'b0;
        addr  = '0;
        mreq  = '0;
        void'($urandom(76475));
        $readmemh("ecc_mem_golden.txt", golden);
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_value("ack", ack, 1'b0);
        pos = 0;
        while (golden[pos] !== END_MARK) begin
            if ($isunknown(golden[pos])) begin
                abort_run("The golden file ended before its counter line.");
            end
            op             = mem_op_e'(golden[pos][1:0]);
            wword.data     = golden[pos+2];
            wword.check    = golden[pos+3][ECC_CHECK_WIDTH-1:0];
            exp_word.data  = golden[pos+4];
            exp_word.check = golden[pos+5][ECC_CHECK_WIDTH-1:0];
            exp_status     = ecc_status_e'(golden[pos+6][1:0]);
            run_operation(op, golden[pos+1][ADDR_WIDTH-1:0], wword, exp_word, exp_status);
            pos += 7;
        end
        check_value("corr_count", corr_count, golden[pos+1]);
        check_value("uncorr_count", uncorr_count, golden[pos+2]);
        check_value("last_err_addr", last_err_addr, golden[pos+3]);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* ecc_mem_golden.txt */
// op addr wdata wcheck exp_data exp_check exp_status (op 0 rd, 1 wr, 2 raw wr, 3 raw rd)
// Last line: E corr_count uncorr_count last_err_addr
1 0 00000000FF 00 00000000FF 03 0
3 0 0000000000 00 00000000FF 03 0
0 0 0000000000 00 00000000FF 03 0
1 1 5A5A5A5A5A 00 5A5A5A5A5A 2E 0
3 1 0000000000 00 5A5A5A5A5A 2E 0
1 2 FFFFFFFFFF 7F FFFFFFFFFF 50 0
0 2 0000000000 00 FFFFFFFFFF 50 0
2 3 5A5A4A5A5A 2E 5A5A4A5A5A 2E 0
0 3 0000000000 00 5A5A5A5A5A 2E 1
0 3 0000000000 00 5A5A5A5A5A 2E 0
2 4 8000000000 00 8000000000 00 0
0 4 0000000000 00 0000000000 00 1
3 4 0000000000 00 0000000000 00 0
2 5 0F00000000 4C 0F00000000 4C 0
0 5 0000000000 00 0F00000000 4C 1
3 5 0000000000 00 0F00000000 0C 0
2 6 8000000002 2D 8000000002 2D 0
0 6 0000000000 00 8000000002 2D 2
3 6 0000000000 00 8000000002 2D 0
2 7 FFFFFFFBFF 51 FFFFFFFBFF 51 0
0 7 0000000000 00 FFFFFFFBFF 51 2
0 1 0000000000 00 5A5A5A5A5A 2E 0
E 3 2 7

/* verilog.f */
ecc_pkg.sv
ecc_secded_40.sv
ecc_mem_array.sv
ecc_mem_ctrl.sv
ecc_err_log.sv
ecc_mem_top.sv
tb_ecc_mem_top.sv

/* Bender.yml */
package:
  name: ecc_mem

sources:
  - ecc_pkg.sv
  - ecc_secded_40.sv
  - ecc_mem_array.sv
  - ecc_mem_ctrl.sv
  - ecc_err_log.sv
  - ecc_mem_top.sv
  - target: simulation
    files:
      - tb_ecc_mem_top.sv
